// ==== Makefile ====
TOP := hwpe_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/apb_cfg_decoder.sv ====
`timescale 1ns/1ps
`include "hwpe_ctrl_params.svh"

module apb_cfg_decoder
  import hwpe_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`HWPE_ADDR_W-1:0] paddr_i,
  input  data_t                   pwdata_i,
  input  core_idx_t               core_id_i,
  output data_t                   prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  input  pending_t                pending_i,    // For the status word
  input  logic                    busy_i,
  cfg_bus_if.decoder              bus
);

  localparam int unsigned WORD_W = `HWPE_ADDR_W - 2;
  localparam logic [WORD_W-1:0] JOB_FIRST = WORD_W'(`HWPE_REG_JOB_BASE);
  localparam logic [WORD_W-1:0] JOB_LAST =
    WORD_W'(`HWPE_REG_JOB_BASE + `HWPE_N_JOB_REGS - 1);
  localparam int unsigned STATUS_BUSY_BIT = 8;

  logic [WORD_W-1:0] word_addr;
  logic              access;
  logic              access_q;
  logic              err;
  cfg_op_e           op;
  data_t             status_word;

  assign word_addr = paddr_i[`HWPE_ADDR_W-1:2];

  // Only the first edge of an access phase counts
  assign access = psel_i & penable_i & ~access_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      access_q <= 1'b0;
    end else begin
      access_q <= access;
    end
  end

  always_comb begin
    op  = OP_NONE;
    err = 1'b0;
    if (word_addr >= JOB_FIRST && word_addr <= JOB_LAST) begin
      op = pwrite_i ? OP_JOB_WR : OP_JOB_RD;
    end else begin
      case (word_addr)
        WORD_W'(`HWPE_REG_TRIGGER):   op = pwrite_i ? OP_TRIGGER : OP_NONE;
        WORD_W'(`HWPE_REG_ACQUIRE):   op = pwrite_i ? OP_NONE : OP_ACQUIRE;
        WORD_W'(`HWPE_REG_STATUS):    op = pwrite_i ? OP_NONE : OP_STATUS;
        WORD_W'(`HWPE_REG_SOFTCLEAR): op = pwrite_i ? OP_SOFTCLEAR : OP_NONE;
        default:                      err = 1'b1;   // Hole in the map
      endcase
    end
  end

  assign bus.valid   = access & (op != OP_NONE);
  assign bus.op      = op;
  assign bus.job_idx = job_idx_t'(word_addr - JOB_FIRST);
  assign bus.wdata   = pwdata_i;
  assign bus.core    = core_id_i;

  always_comb begin
    status_word = '0;
    status_word[$bits(pending_t)-1:0] = pending_i;
    status_word[STATUS_BUSY_BIT]      = busy_i;
  end

  always_comb begin
    case (op)
      OP_ACQUIRE: prdata_o = bus.acq_grant;
      OP_STATUS:  prdata_o = status_word;
      OP_JOB_RD:  prdata_o = bus.rdata_job;
      default:    prdata_o = '0;
    endcase
  end

  assign pready_o  = 1'b1;      // No wait states
  assign pslverr_o = access & err;

endmodule

// ==== hdl/cfg_bus_if.sv ====
`timescale 1ns/1ps
`include "hwpe_ctrl_params.svh"

// Decoded register operations, one per APB access
interface cfg_bus_if
  import hwpe_ctrl_pkg::*;
();

  logic      valid;      // One cycle, on the access edge
  cfg_op_e   op;
  job_idx_t  job_idx;
  data_t     wdata;
  core_idx_t core;

  // Return path to the decoder
  data_t     acq_grant;  // Granted context or busy code
  data_t     rdata_job;

  modport decoder (
    output valid, op, job_idx, wdata, core,
    input  acq_grant, rdata_job
  );

  modport job (
    input  valid, op, job_idx, wdata, core,
    output acq_grant, rdata_job
  );

endinterface

// ==== hdl/hwpe_ctrl_pkg.sv ====
`include "hwpe_ctrl_params.svh"

package hwpe_ctrl_pkg;

  typedef logic [$clog2(`HWPE_N_CONTEXT)-1:0]  ctx_idx_t;
  typedef logic [$clog2(`HWPE_N_CORES)-1:0]    core_idx_t;
  typedef logic [$clog2(`HWPE_N_JOB_REGS)-1:0] job_idx_t;

  // Needs to hold 0 up to N_CONTEXT
  typedef logic [$clog2(`HWPE_N_CONTEXT+1)-1:0] pending_t;

  typedef logic [`HWPE_DATA_W-1:0] data_t;

  // Register set of one context
  typedef data_t [`HWPE_N_JOB_REGS-1:0] job_regs_t;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_TRIGGER,    // Commit, or commit and trigger
    OP_ACQUIRE,
    OP_STATUS,
    OP_SOFTCLEAR,
    OP_JOB_WR,
    OP_JOB_RD
  } cfg_op_e;

endpackage

// ==== hdl/hwpe_ctrl_top.sv ====
`timescale 1ns/1ps
`include "hwpe_ctrl_params.svh"

module hwpe_ctrl_top
  import hwpe_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // APB slave
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [`HWPE_ADDR_W-1:0]  paddr_i,
  input  data_t                    pwdata_i,
  output data_t                    prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  input  core_idx_t                core_id_i,
  // Engine side
  input  logic                     done_i,
  output logic                     start_o,
  output logic                     busy_o,
  output logic                     clear_o,
  output job_regs_t                job_regs_o,
  output logic [`HWPE_N_CORES-1:0] evt_o
);

  ctx_idx_t  pointer_ctx;
  ctx_idx_t  running_ctx;
  pending_t  pending;
  logic      full;
  logic      commit;
  logic      trigger;
  core_idx_t owner_core;
  logic      done_ack;
  logic      clear_regs;

  cfg_bus_if u_cfg_bus ();

  apb_cfg_decoder u_apb_cfg_decoder (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .core_id_i (core_id_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .pending_i (pending),
    .busy_i    (busy_o),
    .bus       (u_cfg_bus)
  );

  job_context_tracker u_job_context_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_o),
    .done_ack_i    (done_ack),
    .bus           (u_cfg_bus),
    .pointer_ctx_o (pointer_ctx),
    .running_ctx_o (running_ctx),
    .pending_o     (pending),
    .full_o        (full),
    .commit_o      (commit),
    .trigger_o     (trigger),
    .owner_core_o  (owner_core)
  );

  job_run_fsm u_job_run_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .done_i        (done_i),
    .commit_i      (commit),
    .trigger_i     (trigger),
    .full_i        (full),
    .pointer_ctx_i (pointer_ctx),
    .running_ctx_i (running_ctx),
    .owner_core_i  (owner_core),
    .bus           (u_cfg_bus),
    .start_o       (start_o),
    .busy_o        (busy_o),
    .done_ack_o    (done_ack),
    .evt_o         (evt_o),
    .clear_o       (clear_o),
    .clear_regs_o  (clear_regs)
  );

  job_regfile u_job_regfile (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_regs),
    .pointer_ctx_i (pointer_ctx),
    .running_ctx_i (running_ctx),
    .bus           (u_cfg_bus),
    .job_regs_o    (job_regs_o)
  );

endmodule

// ==== hdl/job_context_tracker.sv ====
`timescale 1ns/1ps
`include "hwpe_ctrl_params.svh"

module job_context_tracker
  import hwpe_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      done_ack_i,
  cfg_bus_if.job    bus,
  output ctx_idx_t  pointer_ctx_o,   // Context being programmed
  output ctx_idx_t  running_ctx_o,   // Context the engine works on
  output pending_t  pending_o,
  output logic      full_o,
  output logic      commit_o,
  output logic      trigger_o,
  output core_idx_t owner_core_o
);

  typedef enum logic {CTX_IDLE, CTX_PROGRAM} ctx_state_e;

  ctx_state_e ctx_state_q;
  ctx_idx_t   pointer_q;
  ctx_idx_t   running_q;
  pending_t   pending_q;
  core_idx_t  owner_q [`HWPE_N_CONTEXT];
  logic       full;
  logic       can_grant;
  logic       grant;
  logic       commit;

  function automatic ctx_idx_t next_ctx(ctx_idx_t ctx);
    return (ctx == ctx_idx_t'(`HWPE_N_CONTEXT - 1)) ? '0 : ctx + 1'b1;
  endfunction

  assign full      = (pending_q == pending_t'(`HWPE_N_CONTEXT));
  assign can_grant = ~full & (ctx_state_q == CTX_IDLE);
  assign grant     = bus.valid & (bus.op == OP_ACQUIRE) & can_grant;
  assign commit    = bus.valid & (bus.op == OP_TRIGGER) & ~full;   // Dropped when full

  assign bus.acq_grant = can_grant ? data_t'(pointer_q) : `HWPE_ACQUIRE_BUSY;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pointer_q <= '0;
      running_q <= '0;
      pending_q <= '0;
    end else if (clear_i) begin
      pointer_q <= '0;
      running_q <= '0;
      pending_q <= '0;
    end else begin
      if (commit)
        pointer_q <= next_ctx(pointer_q);
      if (done_ack_i)
        running_q <= next_ctx(running_q);
      if (commit && !done_ack_i)
        pending_q <= pending_q + 1'b1;
      else if (!commit && done_ack_i)
        pending_q <= pending_q - 1'b1;
    end
  end

  // Critical section, from granted acquire to commit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctx_state_q <= CTX_IDLE;
    end else if (clear_i) begin
      ctx_state_q <= CTX_IDLE;
    end else begin
      case (ctx_state_q)
        CTX_IDLE:    if (grant) ctx_state_q <= CTX_PROGRAM;
        CTX_PROGRAM: if (commit) ctx_state_q <= CTX_IDLE;
        default:     ctx_state_q <= CTX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (commit)
      owner_q[pointer_q] <= bus.core;   // Who gets the done event
  end

  assign pointer_ctx_o = pointer_q;
  assign running_ctx_o = running_q;
  assign pending_o     = pending_q;
  assign full_o        = full;
  assign commit_o      = commit;
  assign trigger_o     = bus.valid & (bus.op == OP_TRIGGER) & (bus.wdata == '0);
  assign owner_core_o  = owner_q[running_q];

endmodule

// ==== hdl/job_regfile.sv ====
`timescale 1ns/1ps
`include "hwpe_ctrl_params.svh"

module job_regfile
  import hwpe_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  ctx_idx_t  pointer_ctx_i,
  input  ctx_idx_t  running_ctx_i,
  cfg_bus_if.job    bus,
  output job_regs_t job_regs_o
);

  job_regs_t regs_q [`HWPE_N_CONTEXT];
  logic      job_wr;

  assign job_wr = bus.valid & (bus.op == OP_JOB_WR);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < `HWPE_N_CONTEXT; c++)
        regs_q[c] <= '0;
    end else if (clear_i) begin
      for (int c = 0; c < `HWPE_N_CONTEXT; c++)
        regs_q[c] <= '0;
    end else if (job_wr) begin
      regs_q[pointer_ctx_i][bus.job_idx] <= bus.wdata;   // Context being programmed
    end
  end

  // Core sees the context it programs, engine the one it runs
  assign bus.rdata_job = regs_q[pointer_ctx_i][bus.job_idx];
  assign job_regs_o    = regs_q[running_ctx_i];

endmodule

// ==== hdl/job_run_fsm.sv ====
`timescale 1ns/1ps
`include "hwpe_ctrl_params.svh"

module job_run_fsm
  import hwpe_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     done_i,
  input  logic                     commit_i,
  input  logic                     trigger_i,
  input  logic                     full_i,
  input  ctx_idx_t                 pointer_ctx_i,
  input  ctx_idx_t                 running_ctx_i,
  input  core_idx_t                owner_core_i,
  cfg_bus_if.job                   bus,
  output logic                     start_o,
  output logic                     busy_o,
  output logic                     done_ack_o,
  output logic [`HWPE_N_CORES-1:0] evt_o,
  output logic                     clear_o,
  output logic                     clear_regs_o
);

  typedef enum logic [1:0] {RUN_IDLE, RUN_STARTING, RUN_RUN} run_state_e;

  run_state_e      state_q;
  logic            trig_q;       // Trigger remembered for queued jobs
  logic            jobs_avail;
  logic            go;
  logic            sc_wr;
  logic [1:0]      sc_req;
  logic [1:0][1:0] sc_cnt_q;
  logic [1:0]      sc_out_q;

  // A commit in this cycle counts as a queued job
  assign jobs_avail = (running_ctx_i != pointer_ctx_i) | full_i | commit_i;
  assign go         = (trigger_i | trig_q) & jobs_avail;
  assign busy_o     = (state_q != RUN_IDLE);
  assign done_ack_o = done_i & busy_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUN_IDLE;
      trig_q  <= 1'b0;
      start_o <= 1'b0;
      evt_o   <= '0;
    end else if (clear_o) begin
      state_q <= RUN_IDLE;
      trig_q  <= 1'b0;
      start_o <= 1'b0;
      evt_o   <= '0;
    end else begin
      if (trigger_i)
        trig_q <= 1'b1;
      else if (state_q == RUN_IDLE && !jobs_avail)
        trig_q <= 1'b0;
      start_o <= (state_q == RUN_STARTING);
      evt_o   <= done_ack_o ? (`HWPE_N_CORES'(1) << owner_core_i) : '0;
      case (state_q)
        RUN_IDLE:     if (go) state_q <= RUN_STARTING;
        RUN_STARTING: state_q <= RUN_RUN;
        RUN_RUN:      if (done_ack_o) state_q <= RUN_IDLE;
        default:      state_q <= RUN_IDLE;
      endcase
    end
  end

  // Counter 0 drives clear_o, counter 1 the register clear on zero data
  assign sc_wr  = bus.valid & (bus.op == OP_SOFTCLEAR);
  assign sc_req = {sc_wr & (bus.wdata == '0), sc_wr};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sc_cnt_q <= '0;
      sc_out_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (sc_cnt_q[i] == 2'd0 && sc_req[i])
          sc_cnt_q[i] <= 2'd1;
        else if (sc_cnt_q[i] != 2'd0)
          sc_cnt_q[i] <= sc_cnt_q[i] + 2'd1;    // Wraps to zero after three
        sc_out_q[i] <= |sc_cnt_q[i];
      end
    end
  end

  assign clear_o      = sc_out_q[0];
  assign clear_regs_o = sc_out_q[1];

endmodule

// ==== include/hwpe_ctrl_params.svh ====
`ifndef HWPE_CTRL_PARAMS_SVH
`define HWPE_CTRL_PARAMS_SVH

// Sizing of the control slave
`define HWPE_N_CONTEXT  2
`define HWPE_N_CORES    4
`define HWPE_N_JOB_REGS 8
`define HWPE_DATA_W     32
`define HWPE_ADDR_W     8

// Register map, word addresses
`define HWPE_REG_TRIGGER   0   // Write commits, zero data also triggers
`define HWPE_REG_ACQUIRE   1   // Test-and-set read
`define HWPE_REG_STATUS    3
`define HWPE_REG_SOFTCLEAR 4
`define HWPE_REG_JOB_BASE  8

// Acquire result when no context can be granted
`define HWPE_ACQUIRE_BUSY {`HWPE_DATA_W{1'b1}}

`endif

// ==== project.f ====
+incdir+include
hdl/hwpe_ctrl_pkg.sv
hdl/cfg_bus_if.sv
hdl/apb_cfg_decoder.sv
hdl/job_context_tracker.sv
hdl/job_run_fsm.sv
hdl/job_regfile.sv
hdl/hwpe_ctrl_top.sv
sim/hwpe_ctrl_sva.sv
sim/hwpe_ctrl_tb.sv

// ==== sim/hwpe_ctrl_sva.sv ====
`timescale 1ns/1ps
`include "hwpe_ctrl_params.svh"

module hwpe_ctrl_sva (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     start_o,
  input logic                     busy_o,
  input logic                     pready_o,
  input logic [`HWPE_N_CORES-1:0] evt_o
);

  a_start_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_o |=> !start_o)
    else $error("start_o stayed high for more than one cycle");

  a_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_o |-> busy_o)
    else $error("start_o pulsed while busy_o was low");

  // Done event goes to one core at most
  a_evt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(evt_o))
    else $error("evt_o has more than one bit set");

  a_no_wait: assert property (@(posedge clk_i) disable iff (!rst_ni) pready_o)
    else $error("pready_o went low");

endmodule

bind hwpe_ctrl_top hwpe_ctrl_sva u_hwpe_ctrl_sva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .start_o  (start_o),
  .busy_o   (busy_o),
  .pready_o (pready_o),
  .evt_o    (evt_o)
);

// ==== sim/hwpe_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "hwpe_ctrl_params.svh"

module hwpe_ctrl_tb
  import hwpe_ctrl_pkg::*;
();

  localparam int    CLK_PERIOD      = 8;
  localparam int    N_ENTRIES       = 5;
  localparam int    WATCHDOG_CYCLES = N_ENTRIES * 200;
  localparam data_t BUSY_CODE       = `HWPE_ACQUIRE_BUSY;
  localparam data_t SC_SEED         = 32'h6000_9966;

  typedef struct packed {
    core_idx_t core;
    data_t     seed;      // Job register values derive from it
    logic      trigger;   // Commit and trigger, else commit only
    data_t     exp_acq;
  } entry_t;

  typedef struct packed {
    core_idx_t core;
    data_t     seed;
  } job_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     psel_i;
  logic                     penable_i;
  logic                     pwrite_i;
  logic [`HWPE_ADDR_W-1:0]  paddr_i;
  data_t                    pwdata_i;
  data_t                    prdata_o;
  logic                     pready_o;
  logic                     pslverr_o;
  core_idx_t                core_id_i;
  logic                     done_i;
  logic                     start_o;
  logic                     busy_o;
  logic                     clear_o;
  job_regs_t                job_regs_o;
  logic [`HWPE_N_CORES-1:0] evt_o;

  entry_t    stim [N_ENTRIES];
  job_t      job_q [$];      // Committed jobs, in commit order
  core_idx_t owner_q [$];    // Owners of started jobs awaiting their event
  int        model_pending = 0;
  int        model_ptr = 0;
  int        checks = 0;
  int        errors = 0;
  int        n_tests = 0;
  integer    seed = 32'hef308ec6;

  hwpe_ctrl_top u_hwpe_ctrl_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic data_t job_word(data_t seed_val, int idx);
    return seed_val ^ data_t'(32'h0101_0101 * (idx + 1));
  endfunction

  // Pending count in bits 1:0, busy in bit 8
  function automatic data_t expect_status(int pending, logic busy);
    data_t word;
    word    = data_t'(pending);
    word[8] = busy;
    return word;
  endfunction

  task automatic check_eq(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp)
    else begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    n_tests++;
    if (errors == errs_before)
      $display("test %0d %s: ok", n_tests, name);
    else
      $display("test %0d %s: %0d errors", n_tests, name, errors - errs_before);
  endtask

  // Setup phase, access phase, then back to idle
  task automatic do_access(input logic wr, input int word, input data_t wdata,
                           input core_idx_t core, output data_t rdata, output logic err);
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = `HWPE_ADDR_W'(word * 4);
    pwdata_i  = wdata;
    core_id_i = core;
    @(negedge clk_i);
    penable_i = 1'b1;
    #(CLK_PERIOD / 4);    // Read data and error settle before the access edge
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_write(input int word, input data_t wdata, input core_idx_t core,
                           output logic err);
    data_t ignored;
    do_access(1'b1, word, wdata, core, ignored, err);
  endtask

  task automatic apb_read(input int word, input core_idx_t core, output data_t rdata,
                          output logic err);
    do_access(1'b0, word, '0, core, rdata, err);
  endtask

  task automatic wait_engine_idle();
    int waited;
    waited = 0;
    while ((job_q.size() != 0 || owner_q.size() != 0) && waited < 200) begin
      @(negedge clk_i);
      waited++;
    end
    if (job_q.size() != 0 || owner_q.size() != 0) begin
      $display("Engine did not finish the queued jobs within %0d cycles", waited);
      errors++;
    end
  endtask

  task automatic measure_clear(output int cycles);
    int waited;
    waited = 0;
    cycles = 0;
    while (!clear_o && waited < 10) begin
      @(negedge clk_i);
      waited++;
    end
    while (clear_o && cycles < 10) begin
      @(negedge clk_i);
      cycles++;
    end
  endtask

  task automatic run_entry(input entry_t e);
    data_t rd;
    logic  err;
    apb_read(`HWPE_REG_ACQUIRE, e.core, rd, err);
    check_eq("prdata_o (acquire)", rd, e.exp_acq);
    if (e.exp_acq != BUSY_CODE) begin
      // Critical section is held until the commit
      apb_read(`HWPE_REG_ACQUIRE, e.core + 2'd1, rd, err);
      check_eq("prdata_o (acquire, section held)", rd, BUSY_CODE);
      for (int i = 0; i < `HWPE_N_JOB_REGS; i++)
        apb_write(`HWPE_REG_JOB_BASE + i, job_word(e.seed, i), e.core, err);
      for (int i = 0; i < `HWPE_N_JOB_REGS; i++) begin
        apb_read(`HWPE_REG_JOB_BASE + i, e.core, rd, err);
        check_eq($sformatf("prdata_o (job reg %0d)", i), rd, job_word(e.seed, i));
      end
    end
    if (model_pending < `HWPE_N_CONTEXT) begin   // A commit while full is dropped
      job_q.push_back('{core: e.core, seed: e.seed});
      model_pending++;
      model_ptr = (model_ptr + 1) % `HWPE_N_CONTEXT;
    end
    apb_write(`HWPE_REG_TRIGGER, e.trigger ? data_t'(0) : data_t'(1), e.core, err);
    apb_read(`HWPE_REG_STATUS, e.core, rd, err);
    check_eq("prdata_o (status)", rd, expect_status(model_pending, e.trigger));
    if (e.trigger) begin
      wait_engine_idle();
      apb_read(`HWPE_REG_STATUS, e.core, rd, err);
      check_eq("prdata_o (status, idle)", rd, expect_status(model_pending, 1'b0));
    end
  endtask

  // Engine answers each start after 2 to 9 cycles
  initial begin : engine_model
    int delay;
    done_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (start_o) begin
        delay = 2 + ($unsigned($random(seed)) % 8);
        repeat (delay) @(negedge clk_i);
        done_i = 1'b1;
        @(negedge clk_i);
        done_i = 1'b0;
      end
    end
  end

  initial begin : engine_monitor
    job_t      job;
    core_idx_t owner;
    forever begin
      @(negedge clk_i);
      if (start_o) begin
        if (job_q.size() == 0) begin
          $display("start_o pulsed while no committed job was waiting");
          errors++;
        end else begin
          job = job_q.pop_front();
          for (int i = 0; i < `HWPE_N_JOB_REGS; i++)
            check_eq($sformatf("job_regs_o[%0d]", i), job_regs_o[i], job_word(job.seed, i));
          owner_q.push_back(job.core);
        end
      end
      if (evt_o != '0) begin
        if (owner_q.size() == 0) begin
          $display("evt_o pulsed while no job was running");
          errors++;
        end else begin
          owner = owner_q.pop_front();
          check_eq("evt_o", data_t'(evt_o), data_t'(1) << owner);
          model_pending--;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main_sequence
    data_t rd;
    logic  err;
    int    errs;
    int    cycles;
    rst_ni    = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    core_id_i = '0;
    // Two commits fill both contexts, the third trigger write starts both jobs
    stim[0] = '{core: 2'd0, seed: 32'h1000_00a5, trigger: 1'b0, exp_acq: 32'd0};
    stim[1] = '{core: 2'd1, seed: 32'h2000_5a00, trigger: 1'b0, exp_acq: 32'd1};
    stim[2] = '{core: 2'd2, seed: 32'h3000_0000, trigger: 1'b1, exp_acq: BUSY_CODE};
    stim[3] = '{core: 2'd3, seed: 32'h4000_c3c3, trigger: 1'b1, exp_acq: 32'd0};
    stim[4] = '{core: 2'd2, seed: 32'h5000_3c3c, trigger: 1'b1, exp_acq: 32'd1};
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    errs = errors;
    check_eq("start_o", data_t'(start_o), '0);
    check_eq("busy_o", data_t'(busy_o), '0);
    check_eq("clear_o", data_t'(clear_o), '0);
    check_eq("evt_o", data_t'(evt_o), '0);
    check_eq("pslverr_o", data_t'(pslverr_o), '0);
    report_test("reset values", errs);

    for (int k = 0; k < N_ENTRIES; k++) begin
      errs = errors;
      run_entry(stim[k]);
      report_test($sformatf("table entry %0d", k), errs);
    end

    // Soft clear with nonzero data keeps the job registers
    errs = errors;
    apb_read(`HWPE_REG_ACQUIRE, 2'd0, rd, err);
    check_eq("prdata_o (acquire)", rd, data_t'(model_ptr));
    for (int i = 0; i < `HWPE_N_JOB_REGS; i++)
      apb_write(`HWPE_REG_JOB_BASE + i, job_word(SC_SEED, i), 2'd0, err);
    apb_write(`HWPE_REG_TRIGGER, 32'd1, 2'd0, err);
    model_pending++;
    apb_read(`HWPE_REG_STATUS, 2'd0, rd, err);
    check_eq("prdata_o (status)", rd, expect_status(model_pending, 1'b0));
    apb_write(`HWPE_REG_SOFTCLEAR, 32'd1, 2'd0, err);
    model_pending = 0;
    model_ptr     = 0;
    measure_clear(cycles);
    check_eq("clear_o high cycles", data_t'(cycles), 32'd3);
    apb_read(`HWPE_REG_STATUS, 2'd0, rd, err);
    check_eq("prdata_o (status)", rd, expect_status(0, 1'b0));
    for (int i = 0; i < `HWPE_N_JOB_REGS; i++) begin
      apb_read(`HWPE_REG_JOB_BASE + i, 2'd0, rd, err);
      check_eq($sformatf("prdata_o (job reg %0d)", i), rd, job_word(SC_SEED, i));
    end
    report_test("soft clear, registers kept", errs);

    errs = errors;
    apb_write(`HWPE_REG_SOFTCLEAR, 32'd0, 2'd0, err);
    measure_clear(cycles);
    check_eq("clear_o high cycles", data_t'(cycles), 32'd3);
    for (int i = 0; i < `HWPE_N_JOB_REGS; i++) begin
      apb_read(`HWPE_REG_JOB_BASE + i, 2'd0, rd, err);
      check_eq($sformatf("prdata_o (job reg %0d)", i), rd, '0);
      check_eq($sformatf("job_regs_o[%0d]", i), job_regs_o[i], '0);
    end
    report_test("soft clear, registers cleared", errs);

    errs = errors;
    apb_read(2, 2'd0, rd, err);     // Hole between ACQUIRE and STATUS
    check_eq("pslverr_o (word 2)", data_t'(err), 32'd1);
    apb_write(20, 32'hdead_beef, 2'd0, err);
    check_eq("pslverr_o (word 20)", data_t'(err), 32'd1);
    apb_read(`HWPE_REG_STATUS, 2'd0, rd, err);
    check_eq("pslverr_o (status)", data_t'(err), 32'd0);
    report_test("unmapped addresses", errs);

    $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
